//--- all.f
+incdir+include
verilog/decode_pkg.sv
verilog/control_decoder.sv
verilog/imm_gen.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/decode_stage.sv
tests/decode_stage_tb.sv

//--- include/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath and instruction word width
`define XLEN_W 32

// Instruction address width, byte addressed
`define PC_W 16

// Register index width, 32 integer registers
`define REG_W 5

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module decode_stage_tb -f all.f -o decode_sim &&
./obj_dir/decode_sim | grep "TESTBENCH PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tests/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;
  import decode_pkg::*;

  logic      bus, rst, mem_hold;
  word_t     ins, if_id_rs1_data, if_id_rs2_data, ex_mem_alures, wb_res;
  pc_t       if_id_pc;
  reg_addr_t ex_mem_rd, mem_wb_rd;
  logic      ex_mem_regwrite, ex_mem_memread, mem_wb_regwrite;

  reg_addr_t rs1_addr, rs2_addr, id_ex_rd;
  logic      hz, branch_taken;
  pc_t       branch_target, id_ex_pc;
  word_t     id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
  alu_sel_t  id_ex_alu_sel;
  logic      id_ex_alt_op, id_ex_alusrc, id_ex_memread, id_ex_memwrite;
  logic      id_ex_regwrite, id_ex_jal, id_ex_lui, id_ex_auipc;

  // Reference decode of the current inputs
  alu_sel_t  e_alu_sel;
  logic      e_alt, e_alusrc, e_valid, e_br, e_j, e_jr, e_u1, e_u2, e_cond;
  logic [5:0] e_ctrl;
  word_t     e_imm, e_f1, e_f2, e_sum;
  logic      e_hz, e_taken;
  pc_t       e_target;

  // One-entry ID/EX model
  // Control bits in order regwrite, memread, memwrite, jal, lui, auipc
  logic [5:0] m_ctrl;
  reg_addr_t  m_rd;
  pc_t        m_pc;
  word_t      m_rs1, m_rs2, m_imm;
  alu_sel_t   m_alu_sel;
  logic       m_alt, m_alusrc, m_flush;

  // Values for the next issued instruction
  word_t      nxt_rs1, nxt_rs2, nxt_alures, nxt_wb;
  reg_addr_t  nxt_ex_rd, nxt_wb_rd;
  logic       nxt_ex_rw, nxt_ex_mr, nxt_wb_rw;
  int         nxt_hold;
  pc_t        pc;
  int         cycles;

  decode_stage u_decode_stage (.*);

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  // Stop a run that never reaches the end
  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic word_t fwd_ref(input reg_addr_t a, input word_t raw);
    if (a == 5'd0)
      return '0;
    if (ex_mem_regwrite && !ex_mem_memread && ex_mem_rd == a)
      return ex_mem_alures;
    if (mem_wb_regwrite && mem_wb_rd == a)
      return wb_res;
    return raw;
  endfunction

  function automatic logic hz_ref(input reg_addr_t a, input logic used, input logic ctl);
    return used && (a != 5'd0) &&
           ((a == m_rd && m_ctrl[4]) || (ctl && ex_mem_memread && a == ex_mem_rd));
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  always_comb begin
    e_ctrl    = '0;
    e_alu_sel = '0;
    e_alt     = 1'b0;
    e_alusrc  = 1'b0;
    e_valid   = 1'b1;
    e_br      = 1'b0;
    e_j       = 1'b0;
    e_jr      = 1'b0;
    e_u1      = 1'b0;
    e_u2      = 1'b0;
    e_imm     = '0;
    case (ins[6:0])
      OP_LUI:    begin e_ctrl = 6'b100010; e_alusrc = 1'b1; e_imm = {ins[31:12], 12'h000}; end
      OP_AUIPC:  begin e_ctrl = 6'b100001; e_alusrc = 1'b1; e_imm = {ins[31:12], 12'h000}; end
      OP_JAL: begin
        e_ctrl = 6'b100100;
        e_alusrc = 1'b1;
        e_j = 1'b1;
        e_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      OP_JALR: begin
        e_ctrl = 6'b100100;
        e_alusrc = 1'b1;
        e_jr = 1'b1;
        e_u1 = 1'b1;
        e_imm = {{20{ins[31]}}, ins[31:20]};
      end
      OP_BRANCH: begin
        e_br = 1'b1;
        e_u1 = 1'b1;
        e_u2 = 1'b1;
        e_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      OP_LOAD: begin
        e_ctrl = 6'b110000;
        e_alusrc = 1'b1;
        e_u1 = 1'b1;
        e_imm = {{20{ins[31]}}, ins[31:20]};
      end
      OP_STORE: begin
        e_ctrl = 6'b001000;
        e_alusrc = 1'b1;
        e_u1 = 1'b1;
        e_u2 = 1'b1;
        e_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      OP_IMM: begin
        e_ctrl = 6'b100000;
        e_alusrc = 1'b1;
        e_u1 = 1'b1;
        e_alu_sel = ins[14:12];
        e_alt = (ins[14:12] == 3'd5) & ins[30];
        e_imm = {{20{ins[31]}}, ins[31:20]};
      end
      OP_REG: begin
        e_ctrl = 6'b100000;
        e_u1 = 1'b1;
        e_u2 = 1'b1;
        e_alu_sel = ins[14:12];
        e_alt = ins[30];
      end
      default: e_valid = 1'b0;
    endcase
    e_f1 = fwd_ref(ins[19:15], if_id_rs1_data);
    e_f2 = fwd_ref(ins[24:20], if_id_rs2_data);
    e_hz = hz_ref(ins[19:15], e_u1, e_br | e_jr) | hz_ref(ins[24:20], e_u2, e_br | e_jr);
    case (ins[14:12])
      3'd0:    e_cond = (e_f1 == e_f2);
      3'd1:    e_cond = (e_f1 != e_f2);
      3'd4:    e_cond = ($signed(e_f1) < $signed(e_f2));
      3'd5:    e_cond = !($signed(e_f1) < $signed(e_f2));
      3'd6:    e_cond = (e_f1 < e_f2);
      3'd7:    e_cond = !(e_f1 < e_f2);
      default: e_cond = 1'b0;
    endcase
    e_taken  = e_valid && !e_hz && (e_j || e_jr || (e_br && e_cond));
    e_sum    = (e_jr ? e_f1 : {16'h0000, if_id_pc}) + e_imm;
    e_target = e_sum[15:0];
    if (e_jr)
      e_target[0] = 1'b0;
  end

  always @(posedge bus) begin
    if (rst) begin
      m_ctrl  <= '0;
      m_rd    <= '0;
      m_flush <= 1'b0;
    end else if (!mem_hold) begin
      m_flush <= e_taken;
      if (e_hz || m_flush || !e_valid) begin
        m_ctrl <= '0;
        m_rd   <= '0;
      end else begin
        m_ctrl <= e_ctrl;
        m_rd   <= ins[11:7];
      end
    end
    if (!mem_hold) begin
      m_pc      <= if_id_pc;
      m_rs1     <= if_id_rs1_data;
      m_rs2     <= if_id_rs2_data;
      m_imm     <= e_imm;
      m_alu_sel <= e_alu_sel;
      m_alt     <= e_alt;
      m_alusrc  <= e_alusrc;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic compare_field(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
    end
  endtask

  always @(negedge bus) begin
    if (!rst) begin
      compare_field("rs1_addr", 32'(rs1_addr), 32'(ins[19:15]));
      compare_field("rs2_addr", 32'(rs2_addr), 32'(ins[24:20]));
      compare_field("hz", 32'(hz), 32'(e_hz));
      compare_field("branch_taken", 32'(branch_taken), 32'(e_taken));
      if (e_br || e_j || e_jr)
        compare_field("branch_target", 32'(branch_target), 32'(e_target));
      compare_field("id_ex_ctrl", 32'({id_ex_regwrite, id_ex_memread, id_ex_memwrite,
                    id_ex_jal, id_ex_lui, id_ex_auipc}), 32'(m_ctrl));
      compare_field("id_ex_rd", 32'(id_ex_rd), 32'(m_rd));
      compare_field("id_ex_pc", 32'(id_ex_pc), 32'(m_pc));
      compare_field("id_ex_rs1_data", id_ex_rs1_data, m_rs1);
      compare_field("id_ex_rs2_data", id_ex_rs2_data, m_rs2);
      compare_field("id_ex_imm", id_ex_imm, m_imm);
      compare_field("id_ex_alu_sel", 32'(id_ex_alu_sel), 32'(m_alu_sel));
      compare_field("id_ex_alt_op", 32'(id_ex_alt_op), 32'(m_alt));
      compare_field("id_ex_alusrc", 32'(id_ex_alusrc), 32'(m_alusrc));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic word_t random_ins();
    word_t w;
    int    k;
    w = $urandom();
    k = int'($urandom_range(9, 0));
    case (k)
      0: w[6:0] = OP_LUI;
      1: w[6:0] = OP_AUIPC;
      2: w[6:0] = OP_JAL;
      3: w[6:0] = OP_JALR;
      4: w[6:0] = OP_BRANCH;
      5: w[6:0] = OP_LOAD;
      6: w[6:0] = OP_STORE;
      7: w[6:0] = OP_IMM;
      8: w[6:0] = OP_REG;
      default: w[6:0] = 7'b1111111;
    endcase
    // Small register indices so that the later stages often match
    w[11:7]  = 5'($urandom_range(7, 0));
    w[19:15] = 5'($urandom_range(7, 0));
    w[24:20] = 5'($urandom_range(7, 0));
    if (k == 4 && w[14:13] == 2'b01)
      w[14] = 1'b1;
    if (k == 9 && $urandom_range(1, 0) == 0)
      w = '0;
    return w;
  endfunction

  task automatic randomize_pipe();
    nxt_rs1    = $urandom();
    nxt_rs2    = ($urandom_range(3, 0) == 0) ? nxt_rs1 : $urandom();
    nxt_alures = $urandom();
    nxt_wb     = $urandom();
    nxt_ex_rd  = 5'($urandom_range(7, 0));
    nxt_wb_rd  = 5'($urandom_range(7, 0));
    nxt_ex_rw  = 1'($urandom_range(1, 0));
    nxt_ex_mr  = ($urandom_range(4, 0) == 0);
    nxt_wb_rw  = 1'($urandom_range(1, 0));
    nxt_hold   = ($urandom_range(19, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
  endtask

  // Present one instruction, then hold it like fetch would during a stall
  task automatic issue(input word_t i);
    @(posedge bus);
    ins             <= i;
    if_id_pc        <= pc;
    if_id_rs1_data  <= nxt_rs1;
    if_id_rs2_data  <= nxt_rs2;
    ex_mem_alures   <= nxt_alures;
    wb_res          <= nxt_wb;
    ex_mem_rd       <= nxt_ex_rd;
    mem_wb_rd       <= nxt_wb_rd;
    ex_mem_regwrite <= nxt_ex_rw;
    ex_mem_memread  <= nxt_ex_mr;
    mem_wb_regwrite <= nxt_wb_rw;
    mem_hold        <= (nxt_hold > 0);
    pc = pc + 16'd4;
    if (nxt_hold > 0) begin
      repeat (nxt_hold) @(posedge bus);
      mem_hold <= 1'b0;
    end
    @(negedge bus);
    while (hz) begin
      // A bubble moves down behind the stalled instruction
      @(posedge bus);
      ex_mem_memread  <= 1'b0;
      ex_mem_regwrite <= 1'b0;
      @(negedge bus);
    end
  endtask

  function automatic word_t itype(input logic [11:0] im, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input opcode_t op);
    return {im, rs1, f3, rd, op};
  endfunction

  function automatic word_t btype(input logic [12:0] off, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  initial begin
    void'($urandom(32'hbd6b5dde));
    cycles = 0;
    rst = 1'b1;
    mem_hold = 1'b0;
    ins = '0;
    if_id_pc = '0;
    if_id_rs1_data = '0;
    if_id_rs2_data = '0;
    ex_mem_alures = '0;
    wb_res = '0;
    ex_mem_rd = '0;
    mem_wb_rd = '0;
    ex_mem_regwrite = 1'b0;
    ex_mem_memread = 1'b0;
    mem_wb_regwrite = 1'b0;
    pc = 16'h0100;
    repeat (8) @(posedge bus);
    rst <= 1'b0;

    // Load then dependent use
    randomize_pipe();
    nxt_hold = 0;
    issue(itype(12'h010, 5'd2, 3'd2, 5'd5, OP_LOAD));
    issue({7'h00, 5'd1, 5'd5, 3'd0, 5'd6, OP_REG});
    // Branch on a load still in EX/MEM
    randomize_pipe();
    nxt_ex_rd = 5'd3;
    nxt_ex_mr = 1'b1;
    nxt_ex_rw = 1'b1;
    nxt_hold  = 0;
    issue(btype(13'h0010, 5'd3, 5'd3, 3'd0));
    // JALR base from EX/MEM over MEM/WB, then an x0 base
    randomize_pipe();
    nxt_ex_rd = 5'd4;
    nxt_wb_rd = 5'd4;
    nxt_ex_rw = 1'b1;
    nxt_ex_mr = 1'b0;
    nxt_wb_rw = 1'b1;
    nxt_hold  = 0;
    issue(itype(12'h021, 5'd4, 3'd0, 5'd1, OP_JALR));
    randomize_pipe();
    nxt_ex_rd = 5'd0;
    nxt_ex_rw = 1'b1;
    nxt_ex_mr = 1'b0;
    nxt_hold  = 0;
    issue(itype(12'h044, 5'd0, 3'd0, 5'd1, OP_JALR));
    // All six conditions with random and then equal operands
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        randomize_pipe();
        nxt_ex_rw = 1'b0;
        nxt_wb_rw = 1'b0;
        nxt_hold  = 0;
        issue(btype(13'h1ff8, 5'd1, 5'd2, 3'(f)));
        randomize_pipe();
        nxt_ex_rw = 1'b0;
        nxt_wb_rw = 1'b0;
        nxt_rs2   = nxt_rs1;
        nxt_hold  = 2;
        issue(btype(13'h0020, 5'd1, 5'd2, 3'(f)));
      end
    end
    // Random instruction stream
    repeat (1500) begin
      randomize_pipe();
      issue(random_ins());
    end
    repeat (3) @(posedge bus);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/100ps

`include "decode_cfg.svh"

module branch_unit (
  input  decode_pkg::word_t fwd_rs1,
  input  decode_pkg::word_t fwd_rs2,
  input  decode_pkg::word_t imm,
  input  decode_pkg::pc_t   if_id_pc,
  input  logic [2:0]        funct3,
  input  logic              is_branch,
  input  logic              is_jal,
  input  logic              is_jalr,
  input  logic              hz,
  output logic              branch_taken,
  output decode_pkg::pc_t   branch_target
);
  import decode_pkg::*;

  logic  cond;
  word_t pc_ext;
  word_t base;
  word_t sum;

  always_comb begin
    case (funct3)
      3'b000:  cond = (fwd_rs1 == fwd_rs2);
      3'b001:  cond = (fwd_rs1 != fwd_rs2);
      3'b100:  cond = ($signed(fwd_rs1) < $signed(fwd_rs2));
      3'b101:  cond = ($signed(fwd_rs1) >= $signed(fwd_rs2));
      3'b110:  cond = (fwd_rs1 < fwd_rs2);
      3'b111:  cond = (fwd_rs1 >= fwd_rs2);
      default: cond = 1'b0;
    endcase
  end

  // Class flags are only set for valid opcodes
  assign branch_taken = !hz && (is_jal || is_jalr || (is_branch && cond));

  //////////////////////////////////////////////////
  // Target address
  //////////////////////////////////////////////////

  assign pc_ext = {{(`XLEN_W - `PC_W){1'b0}}, if_id_pc};

  // JALR is register relative, everything else is PC relative
  assign base = is_jalr ? fwd_rs1 : pc_ext;
  assign sum  = base + imm;

  assign branch_target = {sum[`PC_W-1:1], sum[0] && !is_jalr};

endmodule

//--- verilog/control_decoder.sv
`timescale 1ns/100ps

module control_decoder (
  input  decode_pkg::word_t    ins,
  output decode_pkg::alu_sel_t alu_sel,
  output logic                 alt_op,
  output logic                 alusrc,
  output logic                 memread,
  output logic                 memwrite,
  output logic                 regwrite,
  output logic                 jal,
  output logic                 lui,
  output logic                 auipc,
  output logic                 is_branch,
  output logic                 is_jal,
  output logic                 is_jalr,
  output logic                 uses_rs1,
  output logic                 uses_rs2,
  output logic                 valid
);
  import decode_pkg::*;

  opcode_t  opcode;
  alu_sel_t funct3;
  logic     funct7_b5;

  assign opcode    = ins[6:0];
  assign funct3    = ins[14:12];
  assign funct7_b5 = ins[30];

  always_comb begin
    // Unknown opcodes fall through with everything low
    alu_sel   = '0;
    alt_op    = 1'b0;
    alusrc    = 1'b0;
    memread   = 1'b0;
    memwrite  = 1'b0;
    regwrite  = 1'b0;
    jal       = 1'b0;
    lui       = 1'b0;
    auipc     = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    valid     = 1'b1;
    case (opcode)
      OP_LUI: begin
        lui      = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      OP_AUIPC: begin
        auipc    = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      // Both jumps write the link address in execute
      OP_JAL: begin
        is_jal   = 1'b1;
        jal      = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
      end
      OP_JALR: begin
        is_jalr  = 1'b1;
        jal      = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      OP_BRANCH: begin
        is_branch = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      OP_LOAD: begin
        memread  = 1'b1;
        alusrc   = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      OP_STORE: begin
        memwrite = 1'b1;
        alusrc   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_IMM: begin
        alu_sel  = funct3;
        // Only SRAI carries the alternate bit, the other immediates use it as data
        alt_op   = (funct3 == 3'b101) && funct7_b5;
        alusrc   = 1'b1;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
      end
      OP_REG: begin
        alu_sel  = funct3;
        alt_op   = funct7_b5;
        regwrite = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: valid = 1'b0;
    endcase
  end

endmodule

//--- verilog/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [`XLEN_W-1:0] word_t;
  typedef logic [`PC_W-1:0]   pc_t;
  typedef logic [`REG_W-1:0]  reg_addr_t;

  // funct3 of the instruction, read by execute together with alt_op
  typedef logic [2:0] alu_sel_t;

  typedef logic [6:0] opcode_t;

  //////////////////////////////////////////////////
  // RV32I major opcodes
  //////////////////////////////////////////////////

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic                  bus,
  input  logic                  rst,
  input  logic                  mem_hold,
  input  decode_pkg::word_t     ins,
  input  decode_pkg::pc_t       if_id_pc,
  input  decode_pkg::word_t     if_id_rs1_data,
  input  decode_pkg::word_t     if_id_rs2_data,
  input  decode_pkg::word_t     ex_mem_alures,
  input  decode_pkg::word_t     wb_res,
  input  decode_pkg::reg_addr_t ex_mem_rd,
  input  decode_pkg::reg_addr_t mem_wb_rd,
  input  logic                  ex_mem_regwrite,
  input  logic                  ex_mem_memread,
  input  logic                  mem_wb_regwrite,
  output decode_pkg::reg_addr_t rs1_addr,
  output decode_pkg::reg_addr_t rs2_addr,
  output logic                  hz,
  output logic                  branch_taken,
  output decode_pkg::pc_t       branch_target,
  output decode_pkg::pc_t       id_ex_pc,
  output decode_pkg::word_t     id_ex_rs1_data,
  output decode_pkg::word_t     id_ex_rs2_data,
  output decode_pkg::word_t     id_ex_imm,
  output decode_pkg::reg_addr_t id_ex_rd,
  output decode_pkg::alu_sel_t  id_ex_alu_sel,
  output logic                  id_ex_alt_op,
  output logic                  id_ex_alusrc,
  output logic                  id_ex_memread,
  output logic                  id_ex_memwrite,
  output logic                  id_ex_regwrite,
  output logic                  id_ex_jal,
  output logic                  id_ex_lui,
  output logic                  id_ex_auipc
);
  import decode_pkg::*;

  alu_sel_t  alu_sel;
  logic      alt_op, alusrc, memread, memwrite, regwrite;
  logic      jal, lui, auipc;
  logic      is_branch, is_jal, is_jalr;
  logic      uses_rs1, uses_rs2, valid;
  word_t     imm;
  word_t     fwd_rs1, fwd_rs2;
  reg_addr_t rd;
  logic      flush;
  logic      bubble;

  assign rs1_addr = ins[19:15];
  assign rs2_addr = ins[24:20];
  assign rd       = ins[11:7];

  //////////////////////////////////////////////////
  // Decode blocks
  //////////////////////////////////////////////////

  control_decoder u_control_decoder (
    .ins       (ins),
    .alu_sel   (alu_sel),
    .alt_op    (alt_op),
    .alusrc    (alusrc),
    .memread   (memread),
    .memwrite  (memwrite),
    .regwrite  (regwrite),
    .jal       (jal),
    .lui       (lui),
    .auipc     (auipc),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .uses_rs1  (uses_rs1),
    .uses_rs2  (uses_rs2),
    .valid     (valid)
  );

  imm_gen u_imm_gen (
    .ins (ins),
    .imm (imm)
  );

  operand_forward u_operand_forward (
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .uses_rs1        (uses_rs1),
    .uses_rs2        (uses_rs2),
    .is_branch       (is_branch),
    .is_jalr         (is_jalr),
    .if_id_rs1_data  (if_id_rs1_data),
    .if_id_rs2_data  (if_id_rs2_data),
    .id_ex_rd        (id_ex_rd),
    .id_ex_memread   (id_ex_memread),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_alures   (ex_mem_alures),
    .mem_wb_rd       (mem_wb_rd),
    .mem_wb_regwrite (mem_wb_regwrite),
    .wb_res          (wb_res),
    .fwd_rs1         (fwd_rs1),
    .fwd_rs2         (fwd_rs2),
    .hz              (hz)
  );

  branch_unit u_branch_unit (
    .fwd_rs1       (fwd_rs1),
    .fwd_rs2       (fwd_rs2),
    .imm           (imm),
    .if_id_pc      (if_id_pc),
    .funct3        (ins[14:12]),
    .is_branch     (is_branch),
    .is_jal        (is_jal),
    .is_jalr       (is_jalr),
    .hz            (hz),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  // Stall, wrong-path slot or unknown opcode all go down as a bubble
  assign bubble = hz || flush || !valid;

  always_ff @(posedge bus) begin
    if (rst) begin
      id_ex_regwrite <= 1'b0;
      id_ex_memread  <= 1'b0;
      id_ex_memwrite <= 1'b0;
      id_ex_jal      <= 1'b0;
      id_ex_lui      <= 1'b0;
      id_ex_auipc    <= 1'b0;
      id_ex_rd       <= '0;
      flush          <= 1'b0;
    end else if (!mem_hold) begin
      // Squash the slot behind a taken branch
      flush <= branch_taken;
      if (bubble) begin
        id_ex_regwrite <= 1'b0;
        id_ex_memread  <= 1'b0;
        id_ex_memwrite <= 1'b0;
        id_ex_jal      <= 1'b0;
        id_ex_lui      <= 1'b0;
        id_ex_auipc    <= 1'b0;
        id_ex_rd       <= '0;
      end else begin
        id_ex_regwrite <= regwrite;
        id_ex_memread  <= memread;
        id_ex_memwrite <= memwrite;
        id_ex_jal      <= jal;
        id_ex_lui      <= lui;
        id_ex_auipc    <= auipc;
        id_ex_rd       <= rd;
      end
    end
  end

  // Data fields advance on every open edge, a bubble only kills the control bits.
  // Execute forwards on its own, so the raw register values go through
  always_ff @(posedge bus) begin
    if (!mem_hold) begin
      id_ex_pc       <= if_id_pc;
      id_ex_rs1_data <= if_id_rs1_data;
      id_ex_rs2_data <= if_id_rs2_data;
      id_ex_imm      <= imm;
      id_ex_alu_sel  <= alu_sel;
      id_ex_alt_op   <= alt_op;
      id_ex_alusrc   <= alusrc;
    end
  end

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
  input  decode_pkg::word_t ins,
  output decode_pkg::word_t imm
);
  import decode_pkg::*;

  opcode_t opcode;
  logic    sign;

  assign opcode = ins[6:0];
  assign sign   = ins[31];

  always_comb begin
    case (opcode)
      // I format
      OP_JALR, OP_LOAD, OP_IMM: begin
        imm = {{20{sign}}, ins[31:20]};
      end
      // S format
      OP_STORE: begin
        imm = {{20{sign}}, ins[31:25], ins[11:7]};
      end
      // B format, offset in half words
      OP_BRANCH: begin
        imm = {{19{sign}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      // U format
      OP_LUI, OP_AUIPC: begin
        imm = {ins[31:12], 12'b0};
      end
      // J format
      OP_JAL: begin
        imm = {{11{sign}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      // R type and anything unknown
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- verilog/operand_forward.sv
`timescale 1ns/100ps

module operand_forward (
  input  decode_pkg::reg_addr_t rs1_addr,
  input  decode_pkg::reg_addr_t rs2_addr,
  input  logic                  uses_rs1,
  input  logic                  uses_rs2,
  input  logic                  is_branch,
  input  logic                  is_jalr,
  input  decode_pkg::word_t     if_id_rs1_data,
  input  decode_pkg::word_t     if_id_rs2_data,
  input  decode_pkg::reg_addr_t id_ex_rd,
  input  logic                  id_ex_memread,
  input  decode_pkg::reg_addr_t ex_mem_rd,
  input  logic                  ex_mem_regwrite,
  input  logic                  ex_mem_memread,
  input  decode_pkg::word_t     ex_mem_alures,
  input  decode_pkg::reg_addr_t mem_wb_rd,
  input  logic                  mem_wb_regwrite,
  input  decode_pkg::word_t     wb_res,
  output decode_pkg::word_t     fwd_rs1,
  output decode_pkg::word_t     fwd_rs2,
  output logic                  hz
);
  import decode_pkg::*;

  // Address compares, shared by forwarding and hazard logic
  logic rs1_nz, rs1_id_hit, rs1_ex_hit, rs1_wb_hit;
  logic rs2_nz, rs2_id_hit, rs2_ex_hit, rs2_wb_hit;
  logic ex_fwd_ok;
  logic load_in_mem;
  logic rs1_hz, rs2_hz;

  assign rs1_nz     = (rs1_addr != '0);
  assign rs1_id_hit = (rs1_addr == id_ex_rd);
  assign rs1_ex_hit = (rs1_addr == ex_mem_rd);
  assign rs1_wb_hit = (rs1_addr == mem_wb_rd);

  assign rs2_nz     = (rs2_addr != '0);
  assign rs2_id_hit = (rs2_addr == id_ex_rd);
  assign rs2_ex_hit = (rs2_addr == ex_mem_rd);
  assign rs2_wb_hit = (rs2_addr == mem_wb_rd);

  // A load in EX/MEM has no data yet, only the ALU result can be taken
  assign ex_fwd_ok = ex_mem_regwrite && !ex_mem_memread;

  function automatic word_t pick(input logic nz, input logic ex_hit, input logic wb_hit,
                                 input word_t ex_val, input word_t wb_val, input word_t raw);
    word_t res;
    if (!nz) begin
      res = '0;
    end else if (ex_hit) begin
      res = ex_val;
    end else if (wb_hit) begin
      res = wb_val;
    end else begin
      res = raw;
    end
    return res;
  endfunction

  assign fwd_rs1 = pick(rs1_nz, rs1_ex_hit && ex_fwd_ok, rs1_wb_hit && mem_wb_regwrite,
                        ex_mem_alures, wb_res, if_id_rs1_data);
  assign fwd_rs2 = pick(rs2_nz, rs2_ex_hit && ex_fwd_ok, rs2_wb_hit && mem_wb_regwrite,
                        ex_mem_alures, wb_res, if_id_rs2_data);

  //////////////////////////////////////////////////
  // Load-use hazard
  //////////////////////////////////////////////////

  // Branch operands are needed in decode, so a load one stage further still stalls
  assign load_in_mem = ex_mem_memread && (is_branch || is_jalr);

  assign rs1_hz = uses_rs1 && rs1_nz &&
                  ((rs1_id_hit && id_ex_memread) || (rs1_ex_hit && load_in_mem));
  assign rs2_hz = uses_rs2 && rs2_nz &&
                  ((rs2_id_hit && id_ex_memread) || (rs2_ex_hit && load_in_mem));

  assign hz = rs1_hz || rs2_hz;

endmodule
